// File: hw/fb_defs.svh
////////////////////////////////////////
// raster geometry, widths and latencies of the frame buffer
// defaults give a small raster for short runs; xga values also fit
// FB_H_ACTIVE must be a multiple of FB_PIX_PER_WORD
// FB_OUT_LAT must equal FB_RD_LAT + 2
////////////////////////////////////////
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// horizontal raster in clk cycles
`define FB_H_ACTIVE 64
`define FB_H_FP 4
`define FB_H_SYNC 8
`define FB_H_TOTAL 80

// vertical raster in lines
`define FB_V_ACTIVE 16
`define FB_V_FP 1
`define FB_V_SYNC 2
`define FB_V_TOTAL 20

// counter widths, wide enough for xga totals
`define FB_HCOUNT_W 11
`define FB_VCOUNT_W 10

// pixel and word packing
`define FB_PIX_W 8
`define FB_PIX_PER_WORD 4
`define FB_WORD_W 32

// log2 of FB_H_ACTIVE * FB_V_ACTIVE / FB_PIX_PER_WORD
`define FB_ADDR_W 8

// luma strictly above this becomes white
`define FB_THRESH 127

// test bars take hcount[FB_BAR_SHIFT+2:FB_BAR_SHIFT]
`define FB_BAR_SHIFT 3

// cycles from read request to data, and from raster position to pins
`define FB_RD_LAT 2
`define FB_OUT_LAT 4

`endif

// File: hw/video_pkg.sv
////////////////////////////////////////
// raster-side types for timing, capture and output
// field widths follow fb_defs.svh
////////////////////////////////////////
`include "fb_defs.svh"

package video_pkg;

   // beam position with its decoded sync and blank, all from one clk edge
   typedef struct packed {
      logic [`FB_HCOUNT_W-1:0] hcount;
      logic [`FB_VCOUNT_W-1:0] vcount;
      logic                    hsync;
      logic                    vsync;
      logic                    blank;
   } raster_pos_t;

   // sync bundle as it leaves the chip, active high
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic blank;
   } sync_t;

   // one decoder sample
   // a valid sample with hsync or vsync set is a marker and carries no pixel
   typedef struct packed {
      logic [`FB_PIX_W-1:0] luma;
      logic                 hsync;
      logic                 vsync;
      logic                 valid;
   } cap_sample_t;

   // what the output stage shows
   typedef enum logic {
      MODE_STORED,
      MODE_BARS
   } out_mode_e;

endpackage

// File: hw/fbuf_pkg.sv
////////////////////////////////////////
// memory-side types of the frame store
// one word holds four pixels, leftmost in bits 7:0
////////////////////////////////////////
`include "fb_defs.svh"

package fbuf_pkg;

   // word address, line * words_per_line + column / 4
   typedef logic [`FB_ADDR_W-1:0] fb_addr_t;

   // element 0 is the leftmost pixel on screen
   typedef logic [`FB_PIX_PER_WORD-1:0][`FB_PIX_W-1:0] fb_word_t;

   // write request from capture, held for the whole handshake
   typedef struct packed {
      fb_addr_t addr;
      fb_word_t data;
   } wr_req_t;

   // memory slot owner, decoded from hcount modulo 4
   // the display reads in slot 0, capture writes in slot 2
   typedef enum logic [1:0] {
      SLOT_READ  = 2'd0,
      SLOT_IDLE1 = 2'd1,
      SLOT_WRITE = 2'd2,
      SLOT_IDLE3 = 2'd3
   } slot_e;

endpackage

// File: hw/raster_timing.sv
////////////////////////////////////////
// free-running raster counters
// after reset the first position shown is (0,0)
// last column and last line must lie outside sync
////////////////////////////////////////
`timescale 1ns/10ps
`include "fb_defs.svh"

module raster_timing (
   input  logic                   clk,
   input  logic                   arst_n,
   output video_pkg::raster_pos_t pos
);

   // last value of each counter before wrap
   localparam logic [`FB_HCOUNT_W-1:0] H_LAST = `FB_H_TOTAL - 1;
   localparam logic [`FB_VCOUNT_W-1:0] V_LAST = `FB_V_TOTAL - 1;

   logic [`FB_HCOUNT_W-1:0] h_next;
   logic [`FB_VCOUNT_W-1:0] v_next;

   // next position, line advances on the last column
   always_comb begin
      h_next = (pos.hcount == H_LAST) ? '0 : pos.hcount + 1'b1;
      v_next = pos.vcount;
      if (pos.hcount == H_LAST) begin
         v_next = (pos.vcount == V_LAST) ? '0 : pos.vcount + 1'b1;
      end
   end

   ////////////////////////////////////////
   // counters and decoded flags
   ////////////////////////////////////////

   // flags decode from the next count so they line up with the registered count
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // park on the last blank position, rd_en stays low in reset
         pos.hcount <= H_LAST;
         pos.vcount <= V_LAST;
         pos.hsync  <= 1'b0;
         pos.vsync  <= 1'b0;
         pos.blank  <= 1'b1;
      end else begin
         pos.hcount <= h_next;
         pos.vcount <= v_next;
         // sync pulse follows the front porch
         pos.hsync  <= (h_next >= `FB_H_ACTIVE + `FB_H_FP) &&
                       (h_next <  `FB_H_ACTIVE + `FB_H_FP + `FB_H_SYNC);
         pos.vsync  <= (v_next >= `FB_V_ACTIVE + `FB_V_FP) &&
                       (v_next <  `FB_V_ACTIVE + `FB_V_FP + `FB_V_SYNC);
         // anything outside the active rectangle is blank
         pos.blank  <= (h_next >= `FB_H_ACTIVE) || (v_next >= `FB_V_ACTIVE);
      end
   end

endmodule

// File: hw/video_capture.sv
////////////////////////////////////////
// sample stream to frame store writes
// vsync marker restarts the frame, hsync marker starts the next line
// markers carry no pixel; pixels outside the active area are dropped
// supply at most one valid sample every two cycles
////////////////////////////////////////
`timescale 1ns/10ps
`include "fb_defs.svh"

module video_capture (
   input  logic                   clk,
   input  logic                   arst_n,
   input  video_pkg::cap_sample_t sample,
   input  logic                   wr_ack,
   output fbuf_pkg::wr_req_t      wr_req,
   output logic                   wr_req_valid,
   output logic                   overrun
);

   localparam int unsigned WORDS_PER_LINE = `FB_H_ACTIVE / `FB_PIX_PER_WORD;

   video_pkg::cap_sample_t  thr;
   logic [`FB_VCOUNT_W-1:0] line;
   logic [`FB_HCOUNT_W-1:0] col;
   fbuf_pkg::fb_word_t      pack;
   fbuf_pkg::fb_word_t      pack_next;
   logic                    is_pixel;
   logic                    in_frame;
   logic                    word_done;
   logic                    busy;

   ////////////////////////////////////////
   // threshold stage
   ////////////////////////////////////////

   // luma field of thr already holds the black or white value
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         thr <= '0;
      end else begin
         thr.luma  <= (sample.luma > `FB_THRESH) ? {`FB_PIX_W{1'b1}} : {`FB_PIX_W{1'b0}};
         thr.hsync <= sample.hsync;
         thr.vsync <= sample.vsync;
         thr.valid <= sample.valid;
      end
   end

   ////////////////////////////////////////
   // position tracking and packing
   ////////////////////////////////////////

   assign is_pixel = thr.valid && !thr.vsync && !thr.hsync;
   assign in_frame = (line < `FB_V_ACTIVE) && (col < `FB_H_ACTIVE);

   // new pixel enters at the top, so the first one ends up in element 0
   assign pack_next = {thr.luma, pack[`FB_PIX_PER_WORD-1:1]};

   // fourth pixel of a word, column ends in 2'b11
   assign word_done = is_pixel && in_frame && (&col[1:0]);

   // a handshake is open until wr_ack falls
   assign busy = wr_req_valid || wr_ack;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         line <= '0;
         col  <= '0;
      end else if (thr.valid) begin
         if (thr.vsync) begin
            line <= '0;
            col  <= '0;
         end else if (thr.hsync) begin
            line <= line + 1'b1;
            col  <= '0;
         end else begin
            col <= col + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (is_pixel) begin
         pack <= pack_next;
      end
   end

   ////////////////////////////////////////
   // requester side of the handshake
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_req_valid <= 1'b0;
         overrun      <= 1'b0;
      end else begin
         // word finished while the last one is still in flight is lost, sticky flag
         if (word_done && busy) begin
            overrun <= 1'b1;
         end
         if (word_done && !busy) begin
            wr_req_valid <= 1'b1;
         end else if (wr_ack) begin
            wr_req_valid <= 1'b0;
         end
      end
   end

   // payload only loads with a new request, so it holds through valid and ack
   always_ff @(posedge clk) begin
      if (word_done && !busy) begin
         wr_req.addr <= fbuf_pkg::fb_addr_t'(line * WORDS_PER_LINE +
                                             col / `FB_PIX_PER_WORD);
         wr_req.data <= pack_next;
      end
   end

endmodule

// File: hw/frame_store.sv
////////////////////////////////////////
// single-port frame buffer shared by time slots
// reads in SLOT_READ, writes in SLOT_WRITE, other slots idle
// read data arrives FB_RD_LAT cycles after rd_en
////////////////////////////////////////
`timescale 1ns/10ps
`include "fb_defs.svh"

module frame_store (
   input  logic                   clk,
   input  logic                   arst_n,
   input  video_pkg::raster_pos_t pos,
   input  logic                   rd_en,
   input  fbuf_pkg::fb_addr_t     rd_addr,
   input  fbuf_pkg::wr_req_t      wr_req,
   input  logic                   wr_req_valid,
   output fbuf_pkg::fb_word_t     rd_data,
   output logic                   wr_ack
);

   // one word per four active pixels
   localparam int unsigned DEPTH = (`FB_H_ACTIVE / `FB_PIX_PER_WORD) * `FB_V_ACTIVE;

   fbuf_pkg::fb_word_t mem [DEPTH];
   fbuf_pkg::fb_word_t rd_pipe [`FB_RD_LAT];
   fbuf_pkg::slot_e    slot;
   fbuf_pkg::fb_addr_t mem_addr;
   logic               do_read;
   logic               do_write;

   ////////////////////////////////////////
   // slot arbitration
   ////////////////////////////////////////

   // slot owner repeats every four raster cycles
   assign slot = fbuf_pkg::slot_e'(pos.hcount[1:0]);

   // reads outside the display slot are ignored
   assign do_read = rd_en && (slot == fbuf_pkg::SLOT_READ);

   // write once per request, the raised ack blocks a repeat
   assign do_write = wr_req_valid && !wr_ack && (slot == fbuf_pkg::SLOT_WRITE);

   // one address port, the two users never meet in the same slot
   assign mem_addr = do_write ? wr_req.addr : rd_addr;

   ////////////////////////////////////////
   // array and read pipeline
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[mem_addr] <= wr_req.data;
      end
   end

   // first stage samples the array, later stages just shift
   // so up to FB_RD_LAT reads can be in flight
   always_ff @(posedge clk) begin
      if (do_read) begin
         rd_pipe[0] <= mem[mem_addr];
      end
      for (int i = 1; i < `FB_RD_LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign rd_data = rd_pipe[`FB_RD_LAT-1];

   ////////////////////////////////////////
   // acknowledger side of the handshake
   ////////////////////////////////////////

   // ack rises the cycle after the write
   // and falls once capture has dropped its request
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ack <= 1'b0;
      end else if (do_write) begin
         wr_ack <= 1'b1;
      end else if (!wr_req_valid) begin
         wr_ack <= 1'b0;
      end
   end

endmodule

// File: hw/pixel_output.sv
////////////////////////////////////////
// display fetch, unpack and output register
// pixel and sync_out trail the raster by FB_OUT_LAT cycles
// stored mode shows garbage until the first frame is captured
////////////////////////////////////////
`timescale 1ns/10ps
`include "fb_defs.svh"

module pixel_output (
   input  logic                   clk,
   input  logic                   arst_n,
   input  video_pkg::raster_pos_t pos,
   input  video_pkg::out_mode_e   mode,
   input  fbuf_pkg::fb_word_t     rd_data,
   output logic                   rd_en,
   output fbuf_pkg::fb_addr_t     rd_addr,
   output logic [`FB_PIX_W-1:0]   pixel,
   output video_pkg::sync_t       sync_out
);

   localparam int unsigned WORDS_PER_LINE = `FB_H_ACTIVE / `FB_PIX_PER_WORD;
   // stage whose pixel goes into the output register
   localparam int unsigned SEL_STAGE = `FB_OUT_LAT - 1;
   // reset content of the delay line, blank so the output stays 0
   localparam video_pkg::raster_pos_t POS_IDLE = '{hcount: '0, vcount: '0,
      hsync: 1'b0, vsync: 1'b0, blank: 1'b1};

   video_pkg::raster_pos_t pos_dly [1:SEL_STAGE];
   video_pkg::raster_pos_t pos_ret;
   video_pkg::raster_pos_t pos_sel;
   fbuf_pkg::fb_word_t     word_q;
   logic [`FB_PIX_W-1:0]   bar_pix;
   logic [`FB_PIX_W-1:0]   pix_sel;

   // fetch the word for hcount..hcount+3 once per four cycles
   assign rd_en = (fbuf_pkg::slot_e'(pos.hcount[1:0]) == fbuf_pkg::SLOT_READ) && !pos.blank;
   assign rd_addr = fbuf_pkg::fb_addr_t'(pos.vcount * WORDS_PER_LINE +
                                         pos.hcount / `FB_PIX_PER_WORD);

   // position travelling with the read
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i <= SEL_STAGE; i++) begin
            pos_dly[i] <= POS_IDLE;
         end
      end else begin
         pos_dly[1] <= pos;
         for (int i = 2; i <= SEL_STAGE; i++) begin
            pos_dly[i] <= pos_dly[i-1];
         end
      end
   end

   // stage where the data of a read returns, and the select stage after it
   assign pos_ret = pos_dly[`FB_RD_LAT];
   assign pos_sel = pos_dly[SEL_STAGE];

   // hold the word for its four pixels, next one lands just in time
   always_ff @(posedge clk) begin
      if ((fbuf_pkg::slot_e'(pos_ret.hcount[1:0]) == fbuf_pkg::SLOT_READ) &&
          !pos_ret.blank) begin
         word_q <= rd_data;
      end
   end

   // vertical bars, three hcount bits over five zeros
   assign bar_pix = {pos_sel.hcount[`FB_BAR_SHIFT+2 -: 3], {(`FB_PIX_W-3){1'b0}}};

   always_comb begin
      if (pos_sel.blank) begin
         pix_sel = '0;
      end else if (mode == video_pkg::MODE_BARS) begin
         pix_sel = bar_pix;
      end else begin
         pix_sel = word_q[pos_sel.hcount[1:0]];
      end
   end

   // output register, sync delayed with its pixel
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pixel    <= '0;
         sync_out <= '0;
      end else begin
         pixel    <= pix_sel;
         sync_out <= '{hsync: pos_sel.hsync, vsync: pos_sel.vsync, blank: pos_sel.blank};
      end
   end

endmodule

// File: hw/capture_display_top.sv
////////////////////////////////////////
// capture to frame store to raster output
// one clock for capture and display
////////////////////////////////////////
`timescale 1ns/10ps
`include "fb_defs.svh"

module capture_display_top (
   input  logic                   clk,
   input  logic                   arst_n,
   input  video_pkg::cap_sample_t sample,
   input  video_pkg::out_mode_e   mode,
   output logic [`FB_PIX_W-1:0]   pixel,
   output video_pkg::sync_t       sync_out,
   output logic                   overrun
);

   // raster position shared by store slots and output
   video_pkg::raster_pos_t pos;

   // capture write handshake
   fbuf_pkg::wr_req_t      wr_req;
   logic                   wr_req_valid;
   logic                   wr_ack;

   // display read port
   logic                   rd_en;
   fbuf_pkg::fb_addr_t     rd_addr;
   fbuf_pkg::fb_word_t     rd_data;

   raster_timing i_raster_timing (
      .clk    (clk),
      .arst_n (arst_n),
      .pos    (pos)
   );

   video_capture i_video_capture (
      .clk          (clk),
      .arst_n       (arst_n),
      .sample       (sample),
      .wr_ack       (wr_ack),
      .wr_req       (wr_req),
      .wr_req_valid (wr_req_valid),
      .overrun      (overrun)
   );

   frame_store i_frame_store (
      .clk          (clk),
      .arst_n       (arst_n),
      .pos          (pos),
      .rd_en        (rd_en),
      .rd_addr      (rd_addr),
      .wr_req       (wr_req),
      .wr_req_valid (wr_req_valid),
      .rd_data      (rd_data),
      .wr_ack       (wr_ack)
   );

   pixel_output i_pixel_output (
      .clk      (clk),
      .arst_n   (arst_n),
      .pos      (pos),
      .mode     (mode),
      .rd_data  (rd_data),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .pixel    (pixel),
      .sync_out (sync_out)
   );

endmodule

// File: testbench/capture_display_chk.sv
////////////////////////////////////////
// handshake and output checks, bound into capture_display_top
// fail_cnt holds the number of failed assertions
////////////////////////////////////////
`timescale 1ns/10ps
`include "fb_defs.svh"

module capture_display_chk (
   input logic                 clk,
   input logic                 arst_n,
   input fbuf_pkg::wr_req_t    wr_req,
   input logic                 wr_req_valid,
   input logic                 wr_ack,
   input logic [`FB_PIX_W-1:0] pixel,
   input video_pkg::sync_t     sync_out
);

   int unsigned fail_cnt = 0;

   // payload holds while a handshake is open
   req_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (wr_req_valid || wr_ack) |=> (!(wr_req_valid || wr_ack) || $stable(wr_req)))
   else begin
      fail_cnt++;
      $error("wr_req changed during an open write handshake");
   end

   // store acknowledges only a pending request
   ack_rise: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(wr_ack) |-> wr_req_valid)
   else begin
      fail_cnt++;
      $error("wr_ack rose without wr_req_valid");
   end

   // black during blank
   blank_black: assert property (@(posedge clk) disable iff (!arst_n)
      sync_out.blank |-> (pixel == '0))
   else begin
      fail_cnt++;
      $error("pixel not zero during blank");
   end

endmodule

bind capture_display_top capture_display_chk i_capture_display_chk (
   .clk          (clk),
   .arst_n       (arst_n),
   .wr_req       (wr_req),
   .wr_req_valid (wr_req_valid),
   .wr_ack       (wr_ack),
   .pixel        (pixel),
   .sync_out     (sync_out)
);

// File: testbench/capture_display_tb.sv
////////////////////////////////////////
// testbench for capture_display_top
// inputs change 2 ns after the rising edge, outputs are read on the falling edge
// raster position is recovered from the fall of output vsync
////////////////////////////////////////
`timescale 1ns/10ps
`include "fb_defs.svh"

module capture_display_tb;

   localparam int CLK_PERIOD  = 20;
   localparam int DRIVE_DLY   = 2;
   localparam int RESET_CYC   = 10;
   localparam int CAP_SPACING = 4;
   localparam int unsigned SEED = 32'h5b01_5b62;
   localparam int FRAME_CYC = `FB_H_TOTAL * `FB_V_TOTAL;
   // output line shown right after vsync falls
   localparam int V_START = `FB_V_ACTIVE + `FB_V_FP + `FB_V_SYNC;
   // vsync marker, then every line with its hsync marker
   localparam int CAP_CYC = (1 + `FB_V_ACTIVE * (`FB_H_ACTIVE + 1)) * CAP_SPACING;
   // bars 1+2, capture, stored 1+1, overrun burst 1
   localparam int FRAMES_USED = 3 + (CAP_CYC + FRAME_CYC - 1) / FRAME_CYC + 2 + 1;
   localparam longint TIMEOUT_NS = longint'(FRAMES_USED + 2) * FRAME_CYC * CLK_PERIOD;

   logic                   clk;
   logic                   arst_n;
   video_pkg::cap_sample_t sample;
   video_pkg::out_mode_e   mode;
   logic [`FB_PIX_W-1:0]   pixel;
   video_pkg::sync_t       sync_out;
   logic                   overrun;

   // thresholded reference image
   logic [`FB_PIX_W-1:0] model_frame [`FB_V_ACTIVE][`FB_H_ACTIVE];
   int unsigned          chk_cnt;
   int unsigned          err_cnt;
   int unsigned          asrt_fails;

   capture_display_top i_capture_display_top (
      .clk      (clk),
      .arst_n   (arst_n),
      .sample   (sample),
      .mode     (mode),
      .pixel    (pixel),
      .sync_out (sync_out),
      .overrun  (overrun)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic compare_value(input string what, input int got, input int exp);
      chk_cnt++;
      assert (got == exp) else begin
         err_cnt++;
         $display("error %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // three hcount bits on top of the pixel
   function automatic logic [`FB_PIX_W-1:0] bar_value(input int h);
      int level;
      level = (h >> `FB_BAR_SHIFT) % 8;
      return level << (`FB_PIX_W - 3);
   endfunction

   // one valid sample, then idle for the rest of the spacing
   task automatic drive_sample(input logic [7:0] luma, input logic hs, input logic vs,
                               input int spacing);
      @(posedge clk);
      #(DRIVE_DLY);
      sample.luma  = luma;
      sample.hsync = hs;
      sample.vsync = vs;
      sample.valid = 1'b1;
      for (int i = 1; i < spacing; i++) begin
         @(posedge clk);
         #(DRIVE_DLY);
         sample.valid = 1'b0;
      end
   endtask

   task automatic drive_idle();
      @(posedge clk);
      #(DRIVE_DLY);
      sample.valid = 1'b0;
   endtask

   // vsync marker, then each line followed by an hsync marker
   // fills the model when asked to
   task automatic stream_frame(input int lines, input int spacing, input bit fill_model);
      int unsigned rnd;
      logic [7:0]  luma;
      drive_sample(8'h00, 1'b0, 1'b1, spacing);
      for (int v = 0; v < lines; v++) begin
         for (int h = 0; h < `FB_H_ACTIVE; h++) begin
            rnd  = $urandom;
            luma = rnd[7:0];
            if (fill_model) begin
               model_frame[v][h] = (luma > `FB_THRESH) ? 8'd255 : 8'd0;
            end
            drive_sample(luma, 1'b0, 1'b0, spacing);
         end
         drive_sample(8'h00, 1'b1, 1'b0, spacing);
      end
      drive_idle();
   endtask

   // returns on the first falling edge of clk with output vsync low again
   task automatic find_frame_start();
      logic prev;
      logic found;
      prev  = sync_out.vsync;
      found = 1'b0;
      while (!found) begin
         @(negedge clk);
         found = prev && !sync_out.vsync;
         prev  = sync_out.vsync;
      end
   endtask

   task automatic check_frames(input int n_frames, input bit bars);
      int                   h;
      int                   v;
      bit                   active;
      logic [`FB_PIX_W-1:0] exp_pix;
      video_pkg::sync_t     exp_sync;
      find_frame_start();
      for (int k = 0; k < n_frames * FRAME_CYC; k++) begin
         h = k % `FB_H_TOTAL;
         v = (V_START + k / `FB_H_TOTAL) % `FB_V_TOTAL;
         active = (h < `FB_H_ACTIVE) && (v < `FB_V_ACTIVE);
         exp_sync.hsync = (h >= `FB_H_ACTIVE + `FB_H_FP) &&
                          (h < `FB_H_ACTIVE + `FB_H_FP + `FB_H_SYNC);
         exp_sync.vsync = (v >= `FB_V_ACTIVE + `FB_V_FP) &&
                          (v < `FB_V_ACTIVE + `FB_V_FP + `FB_V_SYNC);
         exp_sync.blank = !active;
         if (!active) begin
            exp_pix = '0;
         end else if (bars) begin
            exp_pix = bar_value(h);
         end else begin
            exp_pix = model_frame[v][h];
         end
         compare_value($sformatf("sync_out at (%0d,%0d)", h, v), sync_out, exp_sync);
         compare_value($sformatf("pixel at (%0d,%0d)", h, v), pixel, exp_pix);
         @(negedge clk);
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      clk      = 1'b0;
      arst_n   = 1'b0;
      sample   = '0;
      mode     = video_pkg::MODE_BARS;
      chk_cnt  = 0;
      err_cnt  = 0;
      void'($urandom(SEED));
      // outputs inside reset
      repeat (RESET_CYC - 1) @(posedge clk);
      @(negedge clk);
      compare_value("pixel in reset", pixel, 0);
      compare_value("overrun in reset", overrun, 0);
      compare_value("sync_out in reset", sync_out, 0);
      @(posedge clk);
      #(DRIVE_DLY);
      arst_n = 1'b1;
      // outputs after the first clock edge out of reset
      @(posedge clk);
      @(negedge clk);
      compare_value("pixel after reset", pixel, 0);
      compare_value("overrun after reset", overrun, 0);
      compare_value("hsync after reset", sync_out.hsync, 0);
      compare_value("vsync after reset", sync_out.vsync, 0);
      // sync geometry and bars over two frames
      check_frames(2, 1'b1);
      // capture one frame, then show it
      @(posedge clk);
      #(DRIVE_DLY);
      mode = video_pkg::MODE_STORED;
      stream_frame(`FB_V_ACTIVE, CAP_SPACING, 1'b1);
      @(negedge clk);
      compare_value("overrun after capture", overrun, 0);
      check_frames(1, 1'b0);
      compare_value("overrun after display", overrun, 0);
      // at full rate each line shifts the word phase against the write slot
      stream_frame(4, 1, 1'b0);
      @(negedge clk);
      compare_value("overrun after full-rate burst", overrun, 1);
      asrt_fails = i_capture_display_top.i_capture_display_chk.fail_cnt;
      $display("checks %0d, value errors %0d, assertion failures %0d",
               chk_cnt, err_cnt, asrt_fails);
      if (err_cnt == 0 && asrt_fails == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: compile.f
+incdir+hw
hw/video_pkg.sv
hw/fbuf_pkg.sv
hw/raster_timing.sv
hw/video_capture.sv
hw/frame_store.sv
hw/pixel_output.sv
hw/capture_display_top.sv
testbench/capture_display_chk.sv
testbench/capture_display_tb.sv

// File: Bender.yml
package:
  name: capture_display

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/video_pkg.sv
      - hw/fbuf_pkg.sv
      - hw/raster_timing.sv
      - hw/video_capture.sv
      - hw/frame_store.sv
      - hw/pixel_output.sv
      - hw/capture_display_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/capture_display_chk.sv
      - testbench/capture_display_tb.sv
